//--- list.f
ntt_pkg.sv
ctrl_if.sv
stage_sequencer.sv
issue_counter.sv
memory_control.sv
ntt_controller.sv
ntt_controller_sva.sv
tb_ntt_controller.sv

//--- Makefile
TOP = tb_ntt_controller
RTL = ntt_pkg.sv ctrl_if.sv stage_sequencer.sv issue_counter.sv memory_control.sv ntt_controller.sv

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): list.f *.sv
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f list.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "Verification failed" sim.log; then exit 1; fi
	@grep -q "Verification passed" sim.log

lint:
	verilator --lint-only -Wall --top-module ntt_controller $(RTL)
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f list.f

clean:
	rm -rf obj_dir sim.log

//--- tb_ntt_controller.sv
module tb_ntt_controller;

    timeunit 1ns;
    timeprecision 1ns;

    localparam int RUN_CYCLES = 3 * (int'(ntt_pkg::BUTTERFLIES_PER_STAGE)
        + int'(ntt_pkg::DRAIN_CYCLES)) + int'(ntt_pkg::LAST_STAGE_BUTTERFLIES)
        + int'(ntt_pkg::LAST_DRAIN_CYCLES) + 1;
    localparam int ISSUES_PER_RUN = 3 * int'(ntt_pkg::BUTTERFLIES_PER_STAGE)
        + int'(ntt_pkg::LAST_STAGE_BUTTERFLIES);
    // init wait plus three runs with room for stalls
    localparam int WATCHDOG_CYCLES = int'(ntt_pkg::INIT_CYCLES) + 8 * RUN_CYCLES + 100;

    logic clk = 1'b0;
    logic rst;
    logic start;
    logic operand_valid;
    logic rd_valid;
    logic bf_done;
    logic tf_ren;
    logic r_enable;
    logic w_enable;
    logic ntt_enable;
    logic agu_enable;
    logic agu_enable_k2;
    logic last_stage;
    logic done;
    logic [ntt_pkg::DEPTH_W-1:0] depth;

    int errors = 0;
    int checks = 0;
    int tests = 0;

    ntt_controller dut_i (.*);

    always #50 clk = ~clk;

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_depth(input string name, input logic [ntt_pkg::DEPTH_W-1:0] got,
                               input logic [ntt_pkg::DEPTH_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    // expected outputs for the phase and stage the testbench believes the DUT is in
    task automatic check_outputs(input ntt_pkg::phase_t ph, input int stage);
        logic comp;
        logic drn;
        logic last;
        logic iss;
        logic [ntt_pkg::DEPTH_W-1:0] exp_depth;
        comp = (ph == ntt_pkg::PH_COMPUTE);
        drn  = (ph == ntt_pkg::PH_DRAIN);
        last = (stage == ntt_pkg::NUM_STAGES - 1);
        iss  = comp && operand_valid;
        exp_depth = '0;
        if (iss || drn) begin
            exp_depth = last ? ntt_pkg::LAST_DEPTH : ntt_pkg::DEPTH_W'(stage);
        end
        check_bit("tf_ren", tf_ren, iss);
        check_bit("r_enable", r_enable, iss);
        check_bit("w_enable", w_enable, (comp && bf_done) || drn);
        check_bit("ntt_enable", ntt_enable, (comp || drn) && rd_valid);
        check_bit("agu_enable", agu_enable, comp && !last);
        check_bit("agu_enable_k2", agu_enable_k2, comp && last);
        check_bit("last_stage", last_stage, (comp || drn) && last);
        check_bit("done", done, ph == ntt_pkg::PH_FINISH);
        check_depth("depth", depth, exp_depth);
    endtask

    task automatic drive_inputs(input logic st, input logic ov);
        start         <= st;
        operand_valid <= ov;
        rd_valid      <= 1'($urandom_range(1));
        bf_done       <= 1'($urandom_range(1));
    endtask

    task automatic start_run();
        @(posedge clk);
        drive_inputs(1'b1, 1'b1);
        @(negedge clk);
        check_outputs(ntt_pkg::PH_IDLE, 0);
    endtask

    // follows one run from the start sample through the done cycle
    task automatic run_ntt(input bit random_ov, output int done_cycle);
        ntt_pkg::phase_t ph;
        int stage;
        int issued;
        int drained;
        int issues;
        int bound;
        int dbound;
        int cycles;
        ph = ntt_pkg::PH_COMPUTE;
        stage = 0;
        issued = 0;
        drained = 0;
        issues = 0;
        cycles = 0;
        done_cycle = 0;
        while (ph != ntt_pkg::PH_IDLE) begin
            @(posedge clk);
            drive_inputs(1'b0, random_ov ? ($urandom_range(3) != 0) : 1'b1);
            @(negedge clk);
            cycles++;
            check_outputs(ph, stage);
            if (tf_ren) begin
                issues++;
            end
            // cycle of the first done seen from the DUT
            if (done && done_cycle == 0) begin
                done_cycle = cycles;
            end
            bound = (stage == ntt_pkg::NUM_STAGES - 1) ?
                int'(ntt_pkg::LAST_STAGE_BUTTERFLIES) : int'(ntt_pkg::BUTTERFLIES_PER_STAGE);
            dbound = (stage == ntt_pkg::NUM_STAGES - 1) ?
                int'(ntt_pkg::LAST_DRAIN_CYCLES) : int'(ntt_pkg::DRAIN_CYCLES);
            case (ph)
                ntt_pkg::PH_COMPUTE: begin
                    if (operand_valid) begin
                        issued++;
                    end
                    if (issued == bound) begin
                        issued = 0;
                        ph = ntt_pkg::PH_DRAIN;
                    end
                end
                ntt_pkg::PH_DRAIN: begin
                    drained++;
                    if (drained == dbound) begin
                        drained = 0;
                        if (stage == ntt_pkg::NUM_STAGES - 1) begin
                            ph = ntt_pkg::PH_FINISH;
                        end else begin
                            stage++;
                            ph = ntt_pkg::PH_COMPUTE;
                        end
                    end
                end
                default: ph = ntt_pkg::PH_IDLE;
            endcase
        end
        if (issues != ISSUES_PER_RUN) begin
            errors++;
            $display("run issued %0d butterflies instead of %0d", issues, ISSUES_PER_RUN);
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests++;
        $display("test %s finished with %0d errors", name, errors - errs_before);
    endtask

    task automatic test_reset_idle();
        int errs;
        int cycles;
        errs = errors;
        repeat (2) begin
            @(posedge clk);
            drive_inputs(1'b1, 1'b1);
            @(negedge clk);
            check_outputs(ntt_pkg::PH_IDLE, 0);
        end
        @(posedge clk);
        rst <= 1'b0;
        drive_inputs(1'b1, 1'b1);
        @(negedge clk);
        check_outputs(ntt_pkg::PH_IDLE, 0);
        // start held high must wait out the memory load
        repeat (ntt_pkg::INIT_CYCLES) begin
            @(posedge clk);
            drive_inputs(1'b1, 1'b1);
            @(negedge clk);
            check_outputs(ntt_pkg::PH_IDLE, 0);
        end
        run_ntt(1'b0, cycles);
        finish_test("reset_idle", errs);
    endtask

    task automatic test_full_run();
        int errs;
        int done_cycle;
        errs = errors;
        start_run();
        run_ntt(1'b0, done_cycle);
        if (done_cycle != RUN_CYCLES) begin
            errors++;
            $display("done came %0d cycles after start instead of %0d", done_cycle, RUN_CYCLES);
        end
        finish_test("full_run", errs);
    endtask

    task automatic test_backpressure();
        int errs;
        int cycles;
        errs = errors;
        start_run();
        run_ntt(1'b1, cycles);
        finish_test("backpressure", errs);
    endtask

    task automatic test_idle_outputs();
        int errs;
        errs = errors;
        repeat (16) begin
            @(posedge clk);
            drive_inputs(1'b0, 1'($urandom_range(1)));
            @(negedge clk);
            check_outputs(ntt_pkg::PH_IDLE, 0);
        end
        finish_test("idle_outputs", errs);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run still busy after %0d cycles", WATCHDOG_CYCLES);
        $display("Verification failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h1b42));
        rst           <= 1'b1;
        start         <= 1'b0;
        operand_valid <= 1'b0;
        rd_valid      <= 1'b0;
        bf_done       <= 1'b0;
        test_reset_idle();
        test_full_run();
        test_backpressure();
        test_idle_outputs();
        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- ntt_controller_sva.sv
module ntt_controller_sva (
    input logic clk,
    input logic rst,
    input logic tf_ren,
    input logic r_enable,
    input logic agu_enable,
    input logic agu_enable_k2,
    input logic done
);

    timeunit 1ns;
    timeprecision 1ns;

    // finish is a single-cycle phase
    done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done stayed high for more than one cycle");

    // reads only go out while an address generator runs
    tf_with_read: assert property (@(posedge clk) disable iff (rst)
        tf_ren |-> r_enable && (agu_enable || agu_enable_k2))
        else $error("tf_ren high without r_enable or an address generator");

    // radix-2 and k2 address generators never run together
    agu_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(agu_enable && agu_enable_k2))
        else $error("both address generators enabled at once");

endmodule

bind memory_control ntt_controller_sva sva_i (
    .clk           (clk),
    .rst           (rst),
    .tf_ren        (tf_ren),
    .r_enable      (r_enable),
    .agu_enable    (agu_enable),
    .agu_enable_k2 (agu_enable_k2),
    .done          (done)
);

//--- ntt_controller.sv
module ntt_controller (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,
    input  logic                        operand_valid,
    input  logic                        rd_valid,
    input  logic                        bf_done,
    output logic                        tf_ren,
    output logic                        r_enable,
    output logic                        w_enable,
    output logic                        ntt_enable,
    output logic                        agu_enable,
    output logic                        agu_enable_k2,
    output logic                        last_stage,
    output logic                        done,
    output logic [ntt_pkg::DEPTH_W-1:0] depth
);

    ctrl_if ctl_bus ();

    stage_sequencer u_stage_sequencer (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .ctl   (ctl_bus.seq)
    );

    issue_counter u_issue_counter (
        .clk           (clk),
        .rst           (rst),
        .operand_valid (operand_valid),
        .ctl           (ctl_bus.cnt)
    );

    memory_control u_memory_control (
        .clk           (clk),
        .rst           (rst),
        .rd_valid      (rd_valid),
        .bf_done       (bf_done),
        .ctl           (ctl_bus.res),
        .tf_ren        (tf_ren),
        .r_enable      (r_enable),
        .w_enable      (w_enable),
        .ntt_enable    (ntt_enable),
        .agu_enable    (agu_enable),
        .agu_enable_k2 (agu_enable_k2),
        .last_stage    (last_stage),
        .done          (done),
        .depth         (depth)
    );

endmodule

//--- memory_control.sv
module memory_control (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        rd_valid,
    input  logic                        bf_done,
    ctrl_if.res                         ctl,
    output logic                        tf_ren,
    output logic                        r_enable,
    output logic                        w_enable,
    output logic                        ntt_enable,
    output logic                        agu_enable,
    output logic                        agu_enable_k2,
    output logic                        last_stage,
    output logic                        done,
    output logic [ntt_pkg::DEPTH_W-1:0] depth
);

    logic in_compute;
    logic in_drain;
    logic in_last;
    logic [ntt_pkg::DEPTH_W-1:0] stage_depth;

    assign in_compute = (ctl.phase == ntt_pkg::PH_COMPUTE);
    assign in_drain   = (ctl.phase == ntt_pkg::PH_DRAIN);
    assign in_last    = (ctl.stage == ntt_pkg::LAST_STAGE_IDX);

    // twiddle and operand reads go out with each issue
    assign tf_ren   = ctl.issue;
    assign r_enable = ctl.issue;

    // write back results; drain flushes the pipeline
    assign w_enable   = (in_compute && bf_done) || in_drain;
    assign ntt_enable = (in_compute || in_drain) && rd_valid;

    // radix-2 address gen for early stages, k2 for the last
    assign agu_enable    = in_compute && !in_last;
    assign agu_enable_k2 = in_compute && in_last;
    assign last_stage    = (in_compute || in_drain) && in_last;

    assign done = (ctl.phase == ntt_pkg::PH_FINISH);

    always_comb begin
        if (in_last) begin
            stage_depth = ntt_pkg::LAST_DEPTH;
        end else begin
            stage_depth = {{(ntt_pkg::DEPTH_W - ntt_pkg::STAGE_W){1'b0}}, ctl.stage};
        end
    end

    // depth only valid while twiddles are in use
    always_comb begin
        if (ctl.issue || in_drain) begin
            depth = stage_depth;
        end else begin
            depth = '0;
        end
    end

endmodule

//--- issue_counter.sv
module issue_counter (
    input  logic   clk,
    input  logic   rst,
    input  logic   operand_valid,
    ctrl_if.cnt    ctl
);

    logic [ntt_pkg::DEPTH_W-1:0] bf_cnt;
    logic [ntt_pkg::DEPTH_W-1:0] drain_cnt;
    logic [ntt_pkg::DEPTH_W-1:0] issue_bound;
    logic [ntt_pkg::DEPTH_W-1:0] drain_bound;
    logic                        last_stage;
    logic                        in_drain;

    assign last_stage = (ctl.stage == ntt_pkg::LAST_STAGE_IDX);
    assign in_drain   = (ctl.phase == ntt_pkg::PH_DRAIN);

    // the final stage is shorter on both counts
    always_comb begin
        if (last_stage) begin
            issue_bound = ntt_pkg::LAST_STAGE_BUTTERFLIES;
            drain_bound = ntt_pkg::LAST_DRAIN_CYCLES;
        end else begin
            issue_bound = ntt_pkg::BUTTERFLIES_PER_STAGE;
            drain_bound = ntt_pkg::DRAIN_CYCLES;
        end
    end

    // operand_valid low holds the count
    assign ctl.issue      = (ctl.phase == ntt_pkg::PH_COMPUTE) && operand_valid;
    assign ctl.issue_last = ctl.issue && (bf_cnt == issue_bound - 1'b1);
    assign ctl.drain_last = in_drain && (drain_cnt == drain_bound - 1'b1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bf_cnt <= '0;
        end else if (ctl.issue_last) begin
            bf_cnt <= '0;
        end else if (ctl.issue) begin
            bf_cnt <= bf_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            drain_cnt <= '0;
        end else if (!in_drain || ctl.drain_last) begin
            drain_cnt <= '0;
        end else begin
            drain_cnt <= drain_cnt + 1'b1;
        end
    end

endmodule

//--- stage_sequencer.sv
module stage_sequencer (
    input  logic   clk,
    input  logic   rst,
    input  logic   start,
    ctrl_if.seq    ctl
);

    logic [ntt_pkg::DEPTH_W-1:0] init_cnt;
    logic                        init_done;

    ntt_pkg::phase_t             phase_q;
    ntt_pkg::phase_t             phase_d;
    logic [ntt_pkg::STAGE_W-1:0] stage_q;
    logic                        is_last_stage;

    // wait for memory load before accepting start
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            init_cnt  <= '0;
            init_done <= 1'b0;
        end else if (!init_done) begin
            init_cnt  <= init_cnt + 1'b1;
            init_done <= (init_cnt == ntt_pkg::INIT_CYCLES - 1'b1);
        end
    end

    assign is_last_stage = (stage_q == ntt_pkg::LAST_STAGE_IDX);

    always_comb begin
        phase_d = phase_q;
        case (phase_q)
            ntt_pkg::PH_IDLE: begin
                if (start && init_done) begin
                    phase_d = ntt_pkg::PH_COMPUTE;
                end
            end
            ntt_pkg::PH_COMPUTE: begin
                if (ctl.issue_last) begin
                    phase_d = ntt_pkg::PH_DRAIN;
                end
            end
            ntt_pkg::PH_DRAIN: begin
                if (ctl.drain_last) begin
                    phase_d = is_last_stage ? ntt_pkg::PH_FINISH : ntt_pkg::PH_COMPUTE;
                end
            end
            ntt_pkg::PH_FINISH: begin
                phase_d = ntt_pkg::PH_IDLE;
            end
            default: begin
                phase_d = ntt_pkg::PH_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase_q <= ntt_pkg::PH_IDLE;
        end else begin
            phase_q <= phase_d;
        end
    end

    // stage index moves on once each drain ends
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stage_q <= '0;
        end else if (phase_q == ntt_pkg::PH_FINISH) begin
            stage_q <= '0;
        end else if (ctl.drain_last && !is_last_stage) begin
            stage_q <= stage_q + 1'b1;
        end
    end

    assign ctl.phase = phase_q;
    assign ctl.stage = stage_q;

endmodule

//--- ctrl_if.sv
interface ctrl_if;

    ntt_pkg::phase_t             phase;
    logic [ntt_pkg::STAGE_W-1:0] stage;

    // issue counter flags
    logic issue;
    logic issue_last;
    logic drain_last;

    modport seq (
        output phase,
        output stage,
        input  issue_last,
        input  drain_last
    );

    modport cnt (
        input  phase,
        input  stage,
        output issue,
        output issue_last,
        output drain_last
    );

    modport res (
        input phase,
        input stage,
        input issue
    );

endinterface

//--- ntt_pkg.sv
package ntt_pkg;

    // counter and depth width
    localparam int DEPTH_W = 8;
    localparam int STAGE_W = 2;

    localparam int NUM_STAGES = 4;

    // memory load time after reset
    localparam logic [DEPTH_W-1:0] INIT_CYCLES = 8'd64;

    // butterfly issues per stage
    localparam logic [DEPTH_W-1:0] BUTTERFLIES_PER_STAGE = 8'd32;
    localparam logic [DEPTH_W-1:0] LAST_STAGE_BUTTERFLIES = 8'd16;

    // pipeline drain after each stage
    localparam logic [DEPTH_W-1:0] DRAIN_CYCLES = 8'd12;
    localparam logic [DEPTH_W-1:0] LAST_DRAIN_CYCLES = 8'd2;

    // twiddle depth in the radix-k2 stage
    localparam logic [DEPTH_W-1:0] LAST_DEPTH = 8'd9;

    // index of the final stage
    localparam logic [STAGE_W-1:0] LAST_STAGE_IDX = STAGE_W'(NUM_STAGES - 1);

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_COMPUTE,
        PH_DRAIN,
        PH_FINISH
    } phase_t;

endpackage
